// File: rtl/scan_consts.svh
`ifndef SCAN_CONSTS_SVH
`define SCAN_CONSTS_SVH

// Video widths
`define COLOR_W 8
`define XPOS_W 12
`define YPOS_W 11

// Front panel
`define BTN_W 6
`define RESYNC_CNT_W 8
`define RESYNC_LED_CYCLES 200

// APB register map
`define APB_ADDR_W 4
`define APB_DATA_W 32
`define REG_SYS_CTRL 4'h0
`define REG_CONTROLS 4'h4
`define REG_STATUS 4'h8
`define SYS_CTRL_RST 16'h0000
`define SYS_CTRL_WMASK 16'h003f

// OSD palette, indexed by the overlay colour
`define OSD_COLOR_0 24'h000000
`define OSD_COLOR_1 24'h0000ff
`define OSD_COLOR_2 24'hffff00
`define OSD_COLOR_3 24'hffffff

// Board rev with the red LSB routing problem, 1 clears red bit 0 at the output
`define PCB_R_LSB_FIX 1'b1

`endif

// File: rtl/video_pkg.sv
`default_nettype none

`include "scan_consts.svh"

package video_pkg;

    typedef struct packed {
        logic [`COLOR_W-1:0] r;
        logic [`COLOR_W-1:0] g;
        logic [`COLOR_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        rgb_t rgb;
        logic hsync;
        logic vsync;
        logic de;
    } video_pixel_t;

    typedef struct packed {
        logic bck;
        logic ws;
        logic data;
    } i2s_bus_t;

    typedef struct packed {
        logic [`XPOS_W-1:0] xpos;
        logic [`YPOS_W-1:0] ypos;
    } raster_pos_t;

    typedef struct packed {
        logic enable;
        logic [1:0] color;
    } osd_t;

endpackage

`default_nettype wire

// File: rtl/sys_pkg.sv
`default_nettype none

`include "scan_consts.svh"

package sys_pkg;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`APB_DATA_W-1:0] prdata;
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    // System control word, bit 0 is poweron
    typedef struct packed {
        logic [9:0] reserved;
        logic adap_lm;
        logic audmux_sel;
        logic capture_sel;
        logic hdmirx_reset_n;
        logic isl_reset_n;
        logic poweron;
    } sys_ctrl_t;

endpackage

`default_nettype wire

// File: rtl/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_consts.svh"

module ctrl_regs
    import sys_pkg::*;
(
    input  wire                      CLK27_i,
    input  wire                      po_reset_n,
    input  wire apb_req_t            apb_req_i,
    output apb_rsp_t                 apb_rsp_o,
    input  wire [`BTN_W-1:0]         btn_i,
    input  wire [`RESYNC_CNT_W-1:0]  resync_cnt_i,
    output sys_ctrl_t                sys_ctrl_o
);

    localparam int CTRL_W = $bits(sys_ctrl_t);

    logic access;
    logic hit_sys;
    logic hit_ctl;
    logic hit_sts;
    logic [`APB_DATA_W-1:0] rdata;
    sys_ctrl_t sys_ctrl_q;

    assign access = apb_req_i.psel & apb_req_i.penable;
    assign hit_sys = (apb_req_i.paddr == `REG_SYS_CTRL);
    assign hit_ctl = (apb_req_i.paddr == `REG_CONTROLS);
    assign hit_sts = (apb_req_i.paddr == `REG_STATUS);

    // Only the system control word is writable, reserved bits stay zero
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            sys_ctrl_q <= sys_ctrl_t'(`SYS_CTRL_RST);
        end else if (access && apb_req_i.pwrite && hit_sys) begin
            sys_ctrl_q <= sys_ctrl_t'(apb_req_i.pwdata[CTRL_W-1:0] & `SYS_CTRL_WMASK);
        end
    end

    always_comb begin
        if (hit_sys) begin
            rdata = {{(`APB_DATA_W-CTRL_W){1'b0}}, sys_ctrl_q};
        end else if (hit_ctl) begin
            rdata = {{(`APB_DATA_W-`BTN_W){1'b0}}, btn_i};
        end else if (hit_sts) begin
            rdata = {{(`APB_DATA_W-`RESYNC_CNT_W){1'b0}}, resync_cnt_i};
        end else begin
            rdata = '0;
        end
    end

    // No wait states
    assign apb_rsp_o.prdata = rdata;
    assign apb_rsp_o.pready = 1'b1;
    assign apb_rsp_o.pslverr = access & ~(hit_sys | hit_ctl | hit_sts);

    assign sys_ctrl_o = sys_ctrl_q;

endmodule

`default_nettype wire

// File: rtl/front_panel.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_consts.svh"

module front_panel
    import sys_pkg::*;
(
    input  wire                      CLK27_i,
    input  wire                      po_reset_n,
    input  wire [`BTN_W-1:0]         btn_raw_i,
    input  wire                      resync_strobe_i,
    input  wire sys_ctrl_t           sys_ctrl_i,
    output logic [`BTN_W-1:0]        btn_o,
    output logic [`RESYNC_CNT_W-1:0] resync_cnt_o,
    output logic [2:0]               led_o
);

    localparam int STRETCH_W = $clog2(`RESYNC_LED_CYCLES + 1);

    logic [`BTN_W-1:0] btn_sync1;
    logic [`BTN_W-1:0] btn_sync2;
    logic resync_sync1;
    logic resync_sync2;
    logic resync_prev;
    logic resync_edge;
    logic [STRETCH_W-1:0] stretch_q;
    logic [`RESYNC_CNT_W-1:0] event_cnt_q;

    assign resync_edge = resync_sync2 & ~resync_prev;

    // Buttons are active low, idle high
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_sync1 <= '1;
            btn_sync2 <= '1;
            resync_sync1 <= 1'b0;
            resync_sync2 <= 1'b0;
            resync_prev <= 1'b0;
        end else begin
            btn_sync1 <= btn_raw_i;
            btn_sync2 <= btn_sync1;
            resync_sync1 <= resync_strobe_i;
            resync_sync2 <= resync_sync1;
            resync_prev <= resync_sync2;
        end
    end

    // A new edge restarts the LED pulse
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            stretch_q <= '0;
            event_cnt_q <= '0;
        end else if (resync_edge) begin
            stretch_q <= STRETCH_W'(`RESYNC_LED_CYCLES);
            event_cnt_q <= event_cnt_q + 1'b1;
        end else if (stretch_q != '0) begin
            stretch_q <= stretch_q - 1'b1;
        end
    end

    assign btn_o = btn_sync2;
    assign resync_cnt_o = event_cnt_q;
    // LED order is blue, green, red
    assign led_o = sys_ctrl_i.poweron ?
                   {sys_ctrl_i.adap_lm, sys_ctrl_i.capture_sel, (stretch_q != '0)} : 3'b001;

endmodule

`default_nettype wire

// File: rtl/capture_mux.sv
`timescale 1ns/1ps
`default_nettype none

module capture_mux #(
    parameter type payload_t = logic
) (
    input  wire           CLK27_i,
    input  wire           po_reset_n,
    input  wire payload_t src0_i,
    input  wire payload_t src1_i,
    input  wire           sel_i,
    output payload_t      out_o
);

    payload_t src0_q1;
    payload_t src0_q2;
    payload_t src1_q1;
    payload_t src1_q2;
    payload_t sel_q;

    // Two input stages per source for pad-to-fabric timing
    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            src0_q1 <= '0;
            src0_q2 <= '0;
            src1_q1 <= '0;
            src1_q2 <= '0;
            sel_q <= '0;
        end else begin
            src0_q1 <= src0_i;
            src0_q2 <= src0_q1;
            src1_q1 <= src1_i;
            src1_q2 <= src1_q1;
            sel_q <= sel_i ? src1_q2 : src0_q2;
        end
    end

    assign out_o = sel_q;

endmodule

`default_nettype wire

// File: rtl/raster_position.sv
`timescale 1ns/1ps
`default_nettype none

module raster_position
    import video_pkg::*;
(
    input  wire               CLK27_i,
    input  wire               po_reset_n,
    input  wire video_pixel_t pix_i,
    output raster_pos_t       pos_o
);

    logic hsync_prev;
    logic vsync_prev;
    logic v_start;
    raster_pos_t pos_q;

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hsync_prev <= 1'b0;
            vsync_prev <= 1'b0;
            v_start <= 1'b0;
            pos_q <= '0;
        end else begin
            if (vsync_prev && !pix_i.vsync) begin
                pos_q <= '0;
                v_start <= 1'b0;
            end else if (hsync_prev && !pix_i.hsync) begin
                pos_q.xpos <= '0;
                // No line advance before the first active pixel of the frame
                if (v_start) begin
                    pos_q.ypos <= pos_q.ypos + 1'b1;
                end
            end else if (pix_i.de) begin
                v_start <= 1'b1;
                pos_q.xpos <= pos_q.xpos + 1'b1;
            end
            hsync_prev <= pix_i.hsync;
            vsync_prev <= pix_i.vsync;
        end
    end

    assign pos_o = pos_q;

endmodule

`default_nettype wire

// File: rtl/tx_output_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_consts.svh"

module tx_output_stage
    import video_pkg::*;
(
    input  wire               CLK27_i,
    input  wire               po_reset_n,
    input  wire video_pixel_t pix_i,
    input  wire osd_t         osd_i,
    output video_pixel_t      pix_o
);

    rgb_t osd_rgb;
    video_pixel_t stage1_q;
    video_pixel_t stage2_q;

    always_comb begin
        case (osd_i.color)
            2'd0: osd_rgb = `OSD_COLOR_0;
            2'd1: osd_rgb = `OSD_COLOR_1;
            2'd2: osd_rgb = `OSD_COLOR_2;
            default: osd_rgb = `OSD_COLOR_3;
        endcase
    end

    always_ff @(posedge CLK27_i or negedge po_reset_n) begin
        if (!po_reset_n) begin
            stage1_q <= '0;
            stage2_q <= '0;
        end else begin
            stage1_q <= pix_i;
            if (osd_i.enable) begin
                stage1_q.rgb <= osd_rgb;
            end
            stage2_q <= stage1_q;
            stage2_q.rgb.r[0] <= stage1_q.rgb.r[0] & ~`PCB_R_LSB_FIX;
        end
    end

    assign pix_o = stage2_q;

endmodule

`default_nettype wire

// File: rtl/scan_conv_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_consts.svh"

module scan_conv_top
    import video_pkg::*;
    import sys_pkg::*;
(
    input  wire               CLK27_i,
    input  wire               po_reset_n,
    input  wire apb_req_t     apb_req_i,
    output apb_rsp_t          apb_rsp_o,
    input  wire [`BTN_W-1:0]  BTN_i,
    input  wire               resync_strobe_i,
    input  wire video_pixel_t isl_pix_i,
    input  wire video_pixel_t hdmirx_pix_i,
    input  wire i2s_bus_t     pcm_i2s_i,
    input  wire i2s_bus_t     hdmirx_i2s_i,
    input  wire osd_t         osd_i,
    output video_pixel_t      hdmitx_pix_o,
    output i2s_bus_t          hdmitx_i2s_o,
    output raster_pos_t       xy_pos_o,
    output logic [2:0]        LED_o,
    output logic              ISL_RESET_N_o,
    output logic              HDMIRX_RESET_N_o,
    output logic              AUDMUX_o
);

    sys_ctrl_t sys_ctrl;
    logic [`BTN_W-1:0] btn_sync;
    logic [`RESYNC_CNT_W-1:0] resync_cnt;
    video_pixel_t capt_pix;

    ctrl_regs i_ctrl_regs (
        .CLK27_i      (CLK27_i),
        .po_reset_n   (po_reset_n),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .btn_i        (btn_sync),
        .resync_cnt_i (resync_cnt),
        .sys_ctrl_o   (sys_ctrl)
    );

    front_panel i_front_panel (
        .CLK27_i         (CLK27_i),
        .po_reset_n      (po_reset_n),
        .btn_raw_i       (BTN_i),
        .resync_strobe_i (resync_strobe_i),
        .sys_ctrl_i      (sys_ctrl),
        .btn_o           (btn_sync),
        .resync_cnt_o    (resync_cnt),
        .led_o           (LED_o)
    );

    // src0 is the digitizer / PCM side
    capture_mux #(.payload_t(video_pixel_t)) i_video_mux (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .src0_i     (isl_pix_i),
        .src1_i     (hdmirx_pix_i),
        .sel_i      (sys_ctrl.capture_sel),
        .out_o      (capt_pix)
    );

    capture_mux #(.payload_t(i2s_bus_t)) i_audio_mux (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .src0_i     (pcm_i2s_i),
        .src1_i     (hdmirx_i2s_i),
        .sel_i      (sys_ctrl.capture_sel),
        .out_o      (hdmitx_i2s_o)
    );

    raster_position i_raster_position (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .pix_i      (capt_pix),
        .pos_o      (xy_pos_o)
    );

    tx_output_stage i_tx_output_stage (
        .CLK27_i    (CLK27_i),
        .po_reset_n (po_reset_n),
        .pix_i      (capt_pix),
        .osd_i      (osd_i),
        .pix_o      (hdmitx_pix_o)
    );

    assign ISL_RESET_N_o = sys_ctrl.isl_reset_n;
    assign HDMIRX_RESET_N_o = sys_ctrl.hdmirx_reset_n;
    // Board audio switch select is inverted
    assign AUDMUX_o = ~sys_ctrl.audmux_sel;

endmodule

`default_nettype wire

// File: verif/scan_conv_top_checker.sv
`timescale 1ns/1ps
`default_nettype none

module scan_conv_top_checker
    import video_pkg::*;
    import sys_pkg::*;
(
    input wire               CLK27_i,
    input wire               po_reset_n,
    input wire apb_req_t     apb_req_i,
    input wire apb_rsp_t     apb_rsp_i,
    input wire video_pixel_t isl_pix_i,
    input wire video_pixel_t hdmirx_pix_i,
    input wire               capture_sel_i,
    input wire video_pixel_t hdmitx_pix_i
);

    int unsigned fail_count = 0;

    // Slave never inserts wait states
    pready_high_a: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n) apb_rsp_i.pready
    ) else begin
        fail_count++;
        $error("pready dropped low");
    end

    pslverr_in_access_a: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n)
        apb_rsp_i.pslverr |-> (apb_req_i.psel && apb_req_i.penable)
    ) else begin
        fail_count++;
        $error("pslverr raised outside an access phase");
    end

    // Select is taken at the third capture stage, then two output stages
    de_latency_a: assert property (
        @(posedge CLK27_i) disable iff (!po_reset_n)
        hdmitx_pix_i.de == ($past(capture_sel_i, 3) ? $past(hdmirx_pix_i.de, 5)
                                                    : $past(isl_pix_i.de, 5))
    ) else begin
        fail_count++;
        $error("output de does not follow the selected input de");
    end

endmodule

`default_nettype wire

// File: verif/scan_conv_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "scan_consts.svh"

module scan_conv_top_tb
    import video_pkg::*;
    import sys_pkg::*;
();

    // Well above the length of the whole test sequence
    localparam int TIMEOUT_CYCLES = 3000;

    logic clk27;
    logic po_reset_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic [`BTN_W-1:0] btn;
    logic resync_strobe;
    video_pixel_t isl_pix;
    video_pixel_t hdmirx_pix;
    i2s_bus_t pcm_i2s;
    i2s_bus_t hdmirx_i2s;
    osd_t osd;
    video_pixel_t hdmitx_pix;
    i2s_bus_t hdmitx_i2s;
    raster_pos_t xy_pos;
    logic [2:0] led;
    logic isl_reset_n;
    logic hdmirx_reset_n;
    logic audmux;

    integer seed = 32'h59ac;
    int cycle_cnt = 0;
    logic cur_sel = 1'b0;
    video_pixel_t frame_q[$];

    scan_conv_top i_scan_conv_top (
        .CLK27_i          (clk27),
        .po_reset_n       (po_reset_n),
        .apb_req_i        (apb_req),
        .apb_rsp_o        (apb_rsp),
        .BTN_i            (btn),
        .resync_strobe_i  (resync_strobe),
        .isl_pix_i        (isl_pix),
        .hdmirx_pix_i     (hdmirx_pix),
        .pcm_i2s_i        (pcm_i2s),
        .hdmirx_i2s_i     (hdmirx_i2s),
        .osd_i            (osd),
        .hdmitx_pix_o     (hdmitx_pix),
        .hdmitx_i2s_o     (hdmitx_i2s),
        .xy_pos_o         (xy_pos),
        .LED_o            (led),
        .ISL_RESET_N_o    (isl_reset_n),
        .HDMIRX_RESET_N_o (hdmirx_reset_n),
        .AUDMUX_o         (audmux)
    );

    bind scan_conv_top scan_conv_top_checker i_checker (
        .CLK27_i       (CLK27_i),
        .po_reset_n    (po_reset_n),
        .apb_req_i     (apb_req_i),
        .apb_rsp_i     (apb_rsp_o),
        .isl_pix_i     (isl_pix_i),
        .hdmirx_pix_i  (hdmirx_pix_i),
        .capture_sel_i (sys_ctrl.capture_sel),
        .hdmitx_pix_i  (hdmitx_pix_o)
    );

    initial begin
        clk27 = 1'b0;
        forever begin
            #10 clk27 = ~clk27;
        end
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk27) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_cnt);
            abort_run();
        end else if (i_scan_conv_top.i_checker.fail_count != 0) begin
            $display("An assertion in the checker failed");
            abort_run();
        end
    end

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Setup on one falling edge, access on the next, done when pready is seen
    task automatic apb_access(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic slverr);
        int waits;
        waits = 0;
        @(negedge clk27);
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite = write;
        apb_req.paddr = addr;
        apb_req.pwdata = wdata;
        @(negedge clk27);
        apb_req.penable = 1'b1;
        @(posedge clk27);
        while (apb_rsp.pready !== 1'b1) begin
            waits++;
            if (waits > 8) begin
                $display("APB access to address 0x%0h never completed", addr);
                abort_run();
            end
            @(posedge clk27);
        end
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(negedge clk27);
        apb_req = '0;
    endtask

    task automatic reg_write(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic slverr;
        apb_access(1'b1, addr, data, rdata, slverr);
        check_equal("pslverr", 32'(slverr), 32'(exp_err));
    endtask

    task automatic reg_read(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
        logic [31:0] rdata;
        logic slverr;
        apb_access(1'b0, addr, 32'h0, rdata, slverr);
        check_equal("pslverr", 32'(slverr), 32'(exp_err));
        check_equal("prdata", rdata, exp_data);
    endtask

    function automatic rgb_t osd_palette(input logic [1:0] idx);
        case (idx)
            2'd0: return 24'h000000;
            2'd1: return 24'h0000ff;
            2'd2: return 24'hffff00;
            default: return 24'hffffff;
        endcase
    endfunction

    // Random pixels on both sources, output checked against the selected one
    task automatic run_pixels(input int cycles);
        video_pixel_t pix_hist[$];
        i2s_bus_t i2s_hist[$];
        video_pixel_t exp_pix;
        logic [31:0] rnd;
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk27);
            if (pix_hist.size() >= 5) begin
                exp_pix = pix_hist[pix_hist.size() - 5];
                if (osd.enable) begin
                    exp_pix.rgb = osd_palette(osd.color);
                end
                exp_pix.rgb.r[0] = 1'b0;
                check_equal("hdmitx_pix_o", 32'(hdmitx_pix), 32'(exp_pix));
            end
            if (i2s_hist.size() >= 3) begin
                check_equal("hdmitx_i2s_o", 32'(hdmitx_i2s), 32'(i2s_hist[i2s_hist.size() - 3]));
            end
            rnd = $random(seed);
            isl_pix = rnd[26:0];
            rnd = $random(seed);
            hdmirx_pix = rnd[26:0];
            pcm_i2s = n[2:0];
            hdmirx_i2s = ~n[2:0];
            pix_hist.push_back(cur_sel ? hdmirx_pix : isl_pix);
            i2s_hist.push_back(cur_sel ? hdmirx_i2s : pcm_i2s);
        end
    endtask

    task automatic test_reset_regs();
        check_equal("LED_o", 32'(led), 32'h1);
        check_equal("ISL_RESET_N_o", 32'(isl_reset_n), 32'h0);
        check_equal("HDMIRX_RESET_N_o", 32'(hdmirx_reset_n), 32'h0);
        check_equal("AUDMUX_o", 32'(audmux), 32'h1);
        check_equal("hdmitx_pix_o", 32'(hdmitx_pix), 32'h0);
        check_equal("xy_pos_o", 32'(xy_pos), 32'h0);
        reg_read(`REG_SYS_CTRL, 32'h0, 1'b0);
        reg_write(`REG_SYS_CTRL, 32'hffff_ffff, 1'b0);
        reg_read(`REG_SYS_CTRL, 32'h3f, 1'b0);
        check_equal("ISL_RESET_N_o", 32'(isl_reset_n), 32'h1);
        check_equal("HDMIRX_RESET_N_o", 32'(hdmirx_reset_n), 32'h1);
        check_equal("AUDMUX_o", 32'(audmux), 32'h0);
    endtask

    task automatic test_unmapped();
        reg_read(4'hc, 32'h0, 1'b1);
        reg_write(4'hc, 32'h0, 1'b1);
        reg_read(`REG_SYS_CTRL, 32'h3f, 1'b0);
        // Buttons idle high
        reg_read(`REG_CONTROLS, 32'h3f, 1'b0);
        reg_write(`REG_CONTROLS, 32'h0, 1'b0);
        reg_read(`REG_CONTROLS, 32'h3f, 1'b0);
    endtask

    task automatic test_source_select();
        for (int sel = 0; sel < 2; sel++) begin
            cur_sel = sel[0];
            reg_write(`REG_SYS_CTRL, 32'h07 | {28'h0, cur_sel, 3'b000}, 1'b0);
            run_pixels(40);
        end
    endtask

    task automatic test_overlay();
        for (int c = 0; c < 4; c++) begin
            osd.enable = 1'b1;
            osd.color = c[1:0];
            run_pixels(20);
        end
        osd = '0;
    endtask

    task automatic pulse_resync();
        int waits;
        waits = 0;
        @(negedge clk27);
        resync_strobe = 1'b1;
        repeat (2) @(negedge clk27);
        resync_strobe = 1'b0;
        while (led[0] !== 1'b1) begin
            waits++;
            if (waits > 5) begin
                $display("Red LED did not light within 5 cycles of the resync edge");
                abort_run();
            end
            @(negedge clk27);
        end
        // Powered on, HDMI source, live mode off
        check_equal("LED_o", 32'(led), 32'h3);
        repeat (3) @(negedge clk27);
    endtask

    task automatic test_panel();
        btn = 6'h2a;
        repeat (3) @(negedge clk27);
        reg_read(`REG_CONTROLS, 32'h2a, 1'b0);
        reg_read(`REG_STATUS, 32'h0, 1'b0);
        pulse_resync();
        pulse_resync();
        reg_read(`REG_STATUS, 32'h2, 1'b0);
        // Lit here only because the second edge restarted the pulse
        repeat (`RESYNC_LED_CYCLES - 10) @(negedge clk27);
        check_equal("LED_o[0]", 32'(led[0]), 32'h1);
        repeat (15) @(negedge clk27);
        check_equal("LED_o[0]", 32'(led[0]), 32'h0);
        btn = '1;
    endtask

    task automatic add_pixels(input logic hs, input logic vs, input logic de, input int count);
        video_pixel_t pix;
        pix = '0;
        pix.hsync = hs;
        pix.vsync = vs;
        pix.de = de;
        repeat (count) frame_q.push_back(pix);
    endtask

    task automatic test_raster();
        raster_pos_t exp_q[$];
        logic valid_q[$];
        video_pixel_t pix;
        raster_pos_t model;
        logic prev_h;
        logic prev_v;
        logic started;
        logic valid;
        cur_sel = 1'b0;
        reg_write(`REG_SYS_CTRL, 32'h07, 1'b0);
        hdmirx_pix = '0;
        frame_q.delete();
        add_pixels(1'b0, 1'b0, 1'b0, 6);
        add_pixels(1'b0, 1'b1, 1'b0, 2);
        for (int line = 0; line < 3; line++) begin
            add_pixels(1'b1, 1'b0, 1'b0, 2);
            add_pixels(1'b0, 1'b0, 1'b0, 1);
            add_pixels(1'b0, 1'b0, 1'b1, 4);
            add_pixels(1'b0, 1'b0, 1'b0, 1);
        end
        model = '0;
        prev_h = 1'b0;
        prev_v = 1'b0;
        started = 1'b0;
        // Position is unknown until the model sees a vsync falling edge
        valid = 1'b0;
        for (int n = 0; n < frame_q.size() + 4; n++) begin
            @(negedge clk27);
            if (n >= 4 && valid_q[n - 4]) begin
                check_equal("xy_pos_o", 32'(xy_pos), 32'(exp_q[n - 4]));
            end
            pix = (n < frame_q.size()) ? frame_q[n] : '0;
            isl_pix = pix;
            if (prev_v && !pix.vsync) begin
                model = '0;
                started = 1'b0;
                valid = 1'b1;
            end else if (prev_h && !pix.hsync) begin
                model.xpos = '0;
                if (started) begin
                    model.ypos++;
                end
            end else if (pix.de) begin
                started = 1'b1;
                model.xpos++;
            end
            prev_h = pix.hsync;
            prev_v = pix.vsync;
            exp_q.push_back(model);
            valid_q.push_back(valid);
        end
        // Last pixel of the third line
        check_equal("xy_pos_o", 32'(xy_pos), 32'({12'd4, 11'd2}));
    endtask

    initial begin
        po_reset_n = 1'b0;
        apb_req = '0;
        btn = '1;
        resync_strobe = 1'b0;
        isl_pix = '0;
        hdmirx_pix = '0;
        pcm_i2s = '0;
        hdmirx_i2s = '0;
        osd = '0;
        repeat (8) @(negedge clk27);
        po_reset_n = 1'b1;
        @(negedge clk27);
        test_reset_regs();
        test_unmapped();
        test_source_select();
        test_overlay();
        test_panel();
        test_raster();
        repeat (5) @(negedge clk27);
        if (i_scan_conv_top.i_checker.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("The checker reported assertion failures");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: scan_conv_top.f
+incdir+rtl
rtl/video_pkg.sv
rtl/sys_pkg.sv
rtl/ctrl_regs.sv
rtl/front_panel.sv
rtl/capture_mux.sv
rtl/raster_position.sv
rtl/tx_output_stage.sv
rtl/scan_conv_top.sv
verif/scan_conv_top_checker.sv
verif/scan_conv_top_tb.sv

// File: Makefile
# Verilator simulation of the scan converter top level
VERILATOR ?= verilator
TOP       ?= scan_conv_top_tb
FILELIST  ?= scan_conv_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  := *** PASSED ***

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
